/* vga_display.f */
source/vga_pkg.sv
source/vga_pixel_if.sv
source/vga_timing.sv
source/pattern_gen.sv
source/vga_display_top.sv
tests/tb_vga_display.sv

/* run_sim.sh */
#!/usr/bin/env bash
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert -Wno-fatal --top-module tb_vga_display \
   -Mdir obj_dir -f vga_display.f \
   && ./obj_dir/Vtb_vga_display | tee sim.log \
   && grep -q "Simulation finished: PASS" sim.log \
   && exit 0 \
   || { echo "simulation did not pass, see sim.log"; exit 1; }

/* tests/tb_vga_display.sv */
`timescale 1ns/1ps

module tb_vga_display;

   localparam int HOR    = 32;
   localparam int HOR_FP = 4;
   localparam int HOR_SP = 8;
   localparam int HOR_BP = 4;
   localparam int VER    = 16;
   localparam int VER_FP = 1;
   localparam int VER_SP = 2;
   localparam int VER_BP = 2;

   localparam int HOR_C     = HOR + HOR_FP + HOR_SP + HOR_BP;
   localparam int VER_C     = VER + VER_FP + VER_SP + VER_BP;
   localparam int LINE_CYC  = 2 * HOR_C;
   localparam int FRAME_CYC = VER_C * LINE_CYC;
   // Column and line where each sync pulse begins
   localparam int HS_COL    = HOR + HOR_FP;
   localparam int VS_LINE   = VER + VER_FP;
   localparam int BAR_W     = HOR / 8;
   // Checker squares are 8 by 8 pixels
   localparam int SQUARE    = 8;
   // Cycles after an input change before pixel content is compared
   localparam int SETTLE    = 8;

   localparam vga_pkg::pattern_mode_t MODE_SEQ [0:2] = '{
      vga_pkg::MODE_SOLID, vga_pkg::MODE_BARS, vga_pkg::MODE_CHECKER
   };

   logic          i_clk = 1'b0;
   logic          i_nrst;
   logic [1:0]    i_mode;
   logic [14:0]   i_color;
   logic          o_hs;
   logic          o_vs;
   logic [14:0]   o_rgb;
   logic          o_frame_start;

   logic [1:0]    cur_mode;
   logic [14:0]   cur_color;
   int            chg_id = 0;

   int            sync_errs = 0;
   int            pix_errs = 0;
   int            frame_errs = 0;
   int            prop_errs = 0;
   int            solid_checks = 0;
   int            bar_checks = 0;
   int            checker_checks = 0;
   int            blank_checks = 0;

   // Position tracker state
   logic          hs_q;
   logic          vs_q;
   logic          hs_seen;
   logic          vs_seen;
   logic          pos_ok;
   int            hcyc;
   int            fcyc;
   int            hs_cnt;
   int            fs_cnt;
   int            fs_pos;
   int            rst_cyc;
   int            seen_id;
   int            chg_cyc;
   int            cur_h;
   int            cur_v;
   int            prev_h;
   int            prev_v;

   vga_display_top #(
      .HOR    (HOR),
      .HOR_FP (HOR_FP),
      .HOR_SP (HOR_SP),
      .HOR_BP (HOR_BP),
      .VER    (VER),
      .VER_FP (VER_FP),
      .VER_SP (VER_SP),
      .VER_BP (VER_BP)
   ) i_vga_display_top (
      .i_clk         (i_clk),
      .i_nrst        (i_nrst),
      .i_mode        (i_mode),
      .i_color       (i_color),
      .o_hs          (o_hs),
      .o_vs          (o_vs),
      .o_rgb         (o_rgb),
      .o_frame_start (o_frame_start)
   );

   always #4 i_clk = ~i_clk;

   function automatic logic [14:0] expected_pixel(input int x, input int y,
                                                  input logic [1:0] mode,
                                                  input logic [14:0] color);
      logic [2:0] bar;
      logic       odd;
      bar = 3'(x / BAR_W);
      odd = 1'(((x / SQUARE) ^ (y / SQUARE)) & 1);
      case (mode)
         vga_pkg::MODE_SOLID:   return color;
         vga_pkg::MODE_BARS:    return vga_pkg::BAR_COLORS[bar];
         vga_pkg::MODE_CHECKER: return odd ? ~color : color;
         default:               return 15'h0;
      endcase
   endfunction

   task automatic check_pixel(input int x, input int y);
      logic [14:0] exp_rgb;
      if (x < HOR && y < VER) begin
         if (chg_cyc >= SETTLE) begin
            exp_rgb = expected_pixel(x, y, cur_mode, cur_color);
            assert (o_rgb === exp_rgb) else begin
               pix_errs++;
               $display("error o_rgb at (%0d,%0d): got %h, expected %h", x, y, o_rgb, exp_rgb);
            end
            case (cur_mode)
               vga_pkg::MODE_SOLID:   solid_checks++;
               vga_pkg::MODE_BARS:    bar_checks++;
               default:               checker_checks++;
            endcase
         end
      end else begin
         assert (o_rgb === 15'h0) else begin
            pix_errs++;
            $display("error o_rgb blank at (%0d,%0d): got %h, expected 0", x, y, o_rgb);
         end
         blank_checks++;
      end
   endtask

   // Position tracking and pixel checks on the falling clock edge
   always @(negedge i_clk) begin
      if (!i_nrst || rst_cyc < 3) begin
         assert (o_hs === 1'b1 && o_vs === 1'b1 && o_rgb === 15'h0) else begin
            sync_errs++;
            $display("error o_hs/o_vs/o_rgb near reset: %h %h %h", o_hs, o_vs, o_rgb);
         end
      end
      if (!i_nrst) begin
         hs_q = 1'b1;
         vs_q = 1'b1;
         hs_seen = 1'b0;
         vs_seen = 1'b0;
         pos_ok = 1'b0;
         hcyc = 0;
         fcyc = 0;
         hs_cnt = 0;
         fs_cnt = 0;
         fs_pos = -1;
         rst_cyc = 0;
         seen_id = chg_id;
         chg_cyc = 0;
      end else begin
         if (rst_cyc < 3) begin
            rst_cyc++;
         end
         if (chg_id != seen_id) begin
            seen_id = chg_id;
            chg_cyc = 0;
         end else if (chg_cyc < SETTLE) begin
            chg_cyc++;
         end

         // Column reference from the falling edge of hsync
         if (hs_q && !o_hs) begin
            if (hs_seen) begin
               assert (hcyc + 1 == LINE_CYC) else begin
                  sync_errs++;
                  $display("error o_hs period: %h cycles, expected %h", hcyc + 1, LINE_CYC);
               end
            end
            hs_seen = 1'b1;
            hcyc = 0;
            hs_cnt++;
         end else begin
            hcyc++;
         end
         if (!hs_q && o_hs && hs_seen) begin
            assert (hcyc == 2 * HOR_SP) else begin
               sync_errs++;
               $display("error o_hs low width: %h cycles, expected %h", hcyc, 2 * HOR_SP);
            end
         end

         // Line reference from the falling edge of vsync
         if (vs_q && !o_vs) begin
            if (vs_seen) begin
               assert (fcyc + 1 == FRAME_CYC && hs_cnt == VER_C) else begin
                  sync_errs++;
                  $display("error o_vs frame: %h cycles and %h lines, expected %h and %h",
                           fcyc + 1, hs_cnt, FRAME_CYC, VER_C);
               end
               assert (fs_cnt == 1) else begin
                  frame_errs++;
                  $display("error o_frame_start count per frame: %h, expected 1", fs_cnt);
               end
            end
            vs_seen = 1'b1;
            fcyc = 0;
            hs_cnt = 0;
            fs_cnt = 0;
         end else begin
            fcyc++;
         end
         if (!vs_q && o_vs && vs_seen) begin
            assert (fcyc == VER_SP * LINE_CYC) else begin
               sync_errs++;
               $display("error o_vs low width: %h cycles, expected %h", fcyc, VER_SP * LINE_CYC);
            end
         end
         hs_q = o_hs;
         vs_q = o_vs;

         if (hs_seen && vs_seen) begin
            cur_h = (HS_COL + hcyc / 2) % HOR_C;
            cur_v = (VS_LINE + hs_cnt - ((cur_h >= HS_COL) ? 1 : 0)) % VER_C;
            if (o_frame_start) begin
               fs_cnt++;
               if (fs_pos < 0) begin
                  fs_pos = fcyc;
               end
               assert (cur_h == 0 && cur_v == 0 && hcyc % 2 == 0) else begin
                  frame_errs++;
                  $display("o_frame_start pulsed away from the first pixel of a frame");
               end
               assert (fcyc == fs_pos) else begin
                  frame_errs++;
                  $display("error o_frame_start offset: %h, expected %h", fcyc, fs_pos);
               end
            end
            // Displayed pixel trails the counters by one cycle
            if (pos_ok) begin
               check_pixel(prev_h, prev_v);
            end
            prev_h = cur_h;
            prev_v = cur_v;
            pos_ok = 1'b1;
         end
      end
   end

   // Frame start is a single-cycle strobe
   assert property (@(negedge i_clk) disable iff (!i_nrst) o_frame_start |=> !o_frame_start)
      else begin
         prop_errs++;
         $display("o_frame_start stayed high for more than one cycle");
      end

   // Vsync moves only at a line start while hsync is inactive
   assert property (@(negedge i_clk) disable iff (!i_nrst) (o_vs != $past(o_vs)) |-> o_hs)
      else begin
         prop_errs++;
         $display("o_vs changed while o_hs was low");
      end

   task automatic print_counts();
      $display("errors: sync %0d, pixel %0d, frame %0d, property %0d",
               sync_errs, pix_errs, frame_errs, prop_errs);
   endtask

   task automatic abort_run(input string why);
      $display("%s", why);
      print_counts();
      $display("Simulation finished: FAIL");
      $finish;
   endtask

   task automatic wait_frame_start();
      int n;
      n = 0;
      @(negedge i_clk);
      while (o_frame_start !== 1'b1 && n <= FRAME_CYC + LINE_CYC) begin
         n++;
         @(negedge i_clk);
      end
      if (n > FRAME_CYC + LINE_CYC) begin
         abort_run("timed out waiting for o_frame_start");
      end
   endtask

   task automatic apply_pattern(input logic [1:0] mode, input logic [14:0] color);
      cur_mode = mode;
      cur_color = color;
      i_mode = mode;
      i_color = color;
      chg_id++;
   endtask

   task automatic report_results();
      int total;
      total = sync_errs + pix_errs + frame_errs + prop_errs;
      if (solid_checks == 0 || bar_checks == 0 || checker_checks == 0 || blank_checks == 0) begin
         $display("pixel checks were not reached in every mode");
         total++;
      end
      print_counts();
      if (total == 0) begin
         $display("Simulation finished: PASS");
      end else begin
         $display("Simulation finished: FAIL");
      end
      $finish;
   endtask

   initial begin
      void'($urandom(32'h31da));
      i_nrst = 1'b0;
      apply_pattern(vga_pkg::MODE_SOLID, 15'($urandom));
      repeat (2) @(posedge i_clk);
      #1;
      i_nrst = 1'b1;
      for (int m = 0; m < 3; m++) begin
         // Two frames per mode with a fresh colour each frame
         repeat (2) begin
            wait_frame_start();
            @(posedge i_clk);
            #1;
            apply_pattern(MODE_SEQ[m], 15'($urandom));
         end
      end
      // One more frame so the last pattern is seen in full
      wait_frame_start();
      @(posedge i_clk);
      report_results();
   end

endmodule

/* source/vga_display_top.sv */
`timescale 1ns/1ps

module vga_display_top #(
   parameter int HOR    = 800,
   parameter int HOR_FP = 32,
   parameter int HOR_SP = 128,
   parameter int HOR_BP = 128,
   parameter int VER    = 600,
   parameter int VER_FP = 1,
   parameter int VER_SP = 4,
   parameter int VER_BP = 14
) (
   input  logic         i_clk,
   input  logic         i_nrst,
   input  logic [1:0]   i_mode,
   input  logic [14:0]  i_color,
   output logic         o_hs,
   output logic         o_vs,
   output logic [14:0]  o_rgb,
   output logic         o_frame_start
);

   localparam int H_WIDTH = $clog2(HOR + HOR_FP + HOR_SP + HOR_BP);
   localparam int V_WIDTH = $clog2(VER + VER_FP + VER_SP + VER_BP);

   vga_pkg::rgb_t rgb_out;

   vga_pixel_if #(.H_WIDTH(H_WIDTH), .V_WIDTH(V_WIDTH)) u_pix_if ();

   vga_timing #(
      .HOR    (HOR),
      .HOR_FP (HOR_FP),
      .HOR_SP (HOR_SP),
      .HOR_BP (HOR_BP),
      .VER    (VER),
      .VER_FP (VER_FP),
      .VER_SP (VER_SP),
      .VER_BP (VER_BP)
   ) u_vga_timing (
      .i_clk         (i_clk),
      .i_nrst        (i_nrst),
      .pix_if        (u_pix_if.timing),
      .o_hs          (o_hs),
      .o_vs          (o_vs),
      .o_rgb         (rgb_out),
      .o_frame_start (o_frame_start)
   );

   pattern_gen #(.HOR(HOR)) u_pattern_gen (
      .i_clk   (i_clk),
      .i_nrst  (i_nrst),
      .src_if  (u_pix_if.source),
      .i_mode  (vga_pkg::pattern_mode_t'(i_mode)),
      .i_color (vga_pkg::rgb_t'(i_color))
   );

   assign o_rgb = rgb_out;

endmodule

/* source/pattern_gen.sv */
`timescale 1ns/1ps

module pattern_gen #(
   parameter int HOR = 800
) (
   input  logic                     i_clk,
   input  logic                     i_nrst,
   vga_pixel_if.source              src_if,
   input  vga_pkg::pattern_mode_t   i_mode,
   input  vga_pkg::rgb_t            i_color
);

   // Eight bars across the active width
   localparam int BAR_W = HOR / 8;

   vga_pkg::pattern_mode_t mode_q;
   vga_pkg::rgb_t          color_q;
   logic [2:0]             bar_idx;
   logic                   checker_odd;
   vga_pkg::rgb_t          pix_d;
   vga_pkg::rgb_t          pix_q;
   logic                   valid_q;

   // Mode and colour sampled per request, used from the next one on
   always_ff @(posedge i_clk or negedge i_nrst) begin
      if (!i_nrst) begin
         mode_q <= vga_pkg::MODE_SOLID;
      end else if (src_if.req) begin
         mode_q <= i_mode;
      end
   end

   always_ff @(posedge i_clk) begin
      if (src_if.req) begin
         color_q <= i_color;
      end
   end

   // Requests stay inside the active area, so the index fits
   assign bar_idx = 3'(src_if.h / BAR_W);

   assign checker_odd = src_if.h[vga_pkg::CHECK_SHIFT] ^ src_if.v[vga_pkg::CHECK_SHIFT];

   always_comb begin
      case (mode_q)
         vga_pkg::MODE_SOLID: begin
            pix_d = color_q;
         end
         vga_pkg::MODE_BARS: begin
            pix_d = vga_pkg::BAR_COLORS[bar_idx];
         end
         vga_pkg::MODE_CHECKER: begin
            pix_d = checker_odd ? vga_pkg::rgb_t'(~color_q) : color_q;
         end
         default: begin
            // Unknown code shows black
            pix_d = '0;
         end
      endcase
   end

   // Answer one cycle after the request
   always_ff @(posedge i_clk) begin
      if (src_if.req) begin
         pix_q <= pix_d;
      end
   end

   always_ff @(posedge i_clk or negedge i_nrst) begin
      if (!i_nrst) begin
         valid_q <= 1'b0;
      end else begin
         valid_q <= src_if.req;
      end
   end

   assign src_if.pix   = pix_q;
   assign src_if.valid = valid_q;

endmodule

/* source/vga_timing.sv */
`timescale 1ns/1ps

module vga_timing #(
   parameter int HOR    = 800,
   parameter int HOR_FP = 32,
   parameter int HOR_SP = 128,
   parameter int HOR_BP = 128,
   parameter int VER    = 600,
   parameter int VER_FP = 1,
   parameter int VER_SP = 4,
   parameter int VER_BP = 14
) (
   input  logic            i_clk,
   input  logic            i_nrst,
   vga_pixel_if.timing     pix_if,
   output logic            o_hs,
   output logic            o_vs,
   output vga_pkg::rgb_t   o_rgb,
   output logic            o_frame_start
);

   localparam int HOR_C = HOR + HOR_FP + HOR_SP + HOR_BP;
   localparam int VER_C = VER + VER_FP + VER_SP + VER_BP;
   localparam int H_W   = $clog2(HOR_C);
   localparam int V_W   = $clog2(VER_C);

   localparam logic [H_W-1:0] H_LAST   = H_W'(HOR_C - 1);
   localparam logic [H_W-1:0] H_ACT    = H_W'(HOR);
   localparam logic [H_W-1:0] HS_START = H_W'(HOR + HOR_FP - 1);
   localparam logic [H_W-1:0] HS_END   = H_W'(HOR + HOR_FP + HOR_SP - 1);

   localparam logic [V_W-1:0] V_LAST   = V_W'(VER_C - 1);
   localparam logic [V_W-1:0] V_ACT    = V_W'(VER);
   localparam logic [V_W-1:0] VS_START = V_W'(VER + VER_FP - 1);
   localparam logic [V_W-1:0] VS_END   = V_W'(VER + VER_FP + VER_SP - 1);

   logic             tick;
   logic [H_W-1:0]   h;
   logic [H_W-1:0]   h_next;
   logic             h_wrap;
   logic [V_W-1:0]   v;
   logic [V_W-1:0]   v_next;
   logic [V_W-1:0]   v_line;
   logic             v_wrap;
   logic             v_upd;

   logic             hs;
   logic             hs_start;
   logic             hs_end;
   logic             vs;
   logic             vs_start;
   logic             vs_end;

   vga_pkg::rgb_t    rgb;
   logic             disp_act;
   logic             frame_start;

   // Pixel clock enable, every second i_clk
   always_ff @(posedge i_clk or negedge i_nrst) begin
      if (!i_nrst) begin
         tick <= 1'b0;
      end else begin
         tick <= ~tick;
      end
   end

   // Horizontal counter
   assign h_wrap = (h == H_LAST);
   assign h_next = h_wrap ? '0 : h + 1'b1;

   always_ff @(posedge i_clk or negedge i_nrst) begin
      if (!i_nrst) begin
         h <= '0;
      end else if (tick) begin
         h <= h_next;
      end
   end

   // Vertical counter, steps when the line wraps
   assign v_wrap = (v == V_LAST);
   assign v_next = v_wrap ? '0 : v + 1'b1;
   assign v_upd  = tick & h_wrap;

   always_ff @(posedge i_clk or negedge i_nrst) begin
      if (!i_nrst) begin
         v <= '0;
      end else if (v_upd) begin
         v <= v_next;
      end
   end

   // Next pixel request, clamped into the active area
   assign v_line     = h_wrap ? v_next : v;
   assign pix_if.req = tick;
   assign pix_if.h   = (h_next >= H_ACT) ? '0 : h_next;
   assign pix_if.v   = (v_line >= V_ACT) ? '0 : v_line;

   // Horizontal sync
   assign hs_start = (h == HS_START);
   assign hs_end   = (h == HS_END);

   always_ff @(posedge i_clk or negedge i_nrst) begin
      if (!i_nrst) begin
         hs <= 1'b0;
      end else if (tick & (hs_start | hs_end)) begin
         hs <= hs_start;
      end
   end

   assign o_hs = ~hs;

   // Vertical sync, counted in lines
   assign vs_start = (v == VS_START);
   assign vs_end   = (v == VS_END);

   always_ff @(posedge i_clk or negedge i_nrst) begin
      if (!i_nrst) begin
         vs <= 1'b0;
      end else if (v_upd & (vs_start | vs_end)) begin
         vs <= vs_start;
      end
   end

   assign o_vs = ~vs;

   // Pixel register, holds last answer if valid is missing
   always_ff @(posedge i_clk or negedge i_nrst) begin
      if (!i_nrst) begin
         rgb <= '0;
      end else if (pix_if.valid) begin
         rgb <= pix_if.pix;
      end
   end

   // Active flag of the pixel loaded in the same slot
   always_ff @(posedge i_clk or negedge i_nrst) begin
      if (!i_nrst) begin
         disp_act <= 1'b0;
      end else if (!tick) begin
         disp_act <= (h < H_ACT) & (v < V_ACT);
      end
   end

   assign o_rgb = disp_act ? rgb : '0;

   // Both counters back at zero
   always_ff @(posedge i_clk or negedge i_nrst) begin
      if (!i_nrst) begin
         frame_start <= 1'b0;
      end else begin
         frame_start <= v_upd & v_wrap;
      end
   end

   assign o_frame_start = frame_start;

endmodule

/* source/vga_pixel_if.sv */
`timescale 1ns/1ps

interface vga_pixel_if #(
   parameter int H_WIDTH = 11,
   parameter int V_WIDTH = 10
);

   // Request, one i_clk wide, with the coordinate of the next pixel
   logic                req;
   logic [H_WIDTH-1:0]  h;
   logic [V_WIDTH-1:0]  v;

   // Answer, exactly one i_clk after req
   vga_pkg::rgb_t       pix;
   logic                valid;

   modport timing (
      output req, h, v,
      input  pix, valid
   );

   modport source (
      input  req, h, v,
      output pix, valid
   );

endinterface

/* source/vga_pkg.sv */
package vga_pkg;

   localparam int R_WIDTH = 5;
   localparam int G_WIDTH = 5;
   localparam int B_WIDTH = 5;

   // One pixel, red in the top bits
   typedef struct packed {
      logic [R_WIDTH-1:0] r;
      logic [G_WIDTH-1:0] g;
      logic [B_WIDTH-1:0] b;
   } rgb_t;

   typedef enum logic [1:0] {
      MODE_SOLID   = 2'd0,
      MODE_BARS    = 2'd1,
      MODE_CHECKER = 2'd2
   } pattern_mode_t;

   // Classic colour bars, left to right
   localparam rgb_t BAR_COLORS [0:7] = '{
      '{5'd31, 5'd31, 5'd31},
      '{5'd31, 5'd31, 5'd0},
      '{5'd0,  5'd31, 5'd31},
      '{5'd0,  5'd31, 5'd0},
      '{5'd31, 5'd0,  5'd31},
      '{5'd31, 5'd0,  5'd0},
      '{5'd0,  5'd0,  5'd31},
      '{5'd0,  5'd0,  5'd0}
   };

   // Checker squares are 2**CHECK_SHIFT pixels wide
   localparam int CHECK_SHIFT = 3;

endpackage
